// File: common/decode_consts.svh
`ifndef DECODE_CONSTS_SVH
`define DECODE_CONSTS_SVH

// datapath widths
`define WORD_W      32
`define REG_ADDR_W  5

// instruction fields
`define OP_MSB      31
`define OP_LSB      26
`define RS_LSB      21
`define RT_LSB      16
`define RD_LSB      11
`define SHAMT_LSB   6
`define SHAMT_W     5
`define FUNCT_MSB   5
`define IMM_W       16
`define JIDX_W      26

// jal/jalr write the address past the delay slot
`define LINK_REG    5'd31
`define RET_OFFSET  32'd8

`endif

// File: common/isa_pkg.sv
package isa_pkg;

	// primary opcodes that the decoder accepts
	typedef enum logic [5:0] {
		op_special = 6'h00,
		op_regimm  = 6'h01,
		op_j       = 6'h02,
		op_jal     = 6'h03,
		op_beq     = 6'h04,
		op_bne     = 6'h05,
		op_blez    = 6'h06,
		op_bgtz    = 6'h07,
		op_addi    = 6'h08,
		op_addiu   = 6'h09,
		op_andi    = 6'h0c,
		op_ori     = 6'h0d,
		op_xori    = 6'h0e,
		op_lui     = 6'h0f,
		op_lb      = 6'h20,
		op_lh      = 6'h21,
		op_lw      = 6'h23,
		op_lbu     = 6'h24,
		op_lhu     = 6'h25,
		op_sb      = 6'h28,
		op_sh      = 6'h29,
		op_sw      = 6'h2b
	} opcode_t;

	// funct field of op_special
	typedef enum logic [5:0] {
		fn_sll     = 6'h00,
		fn_srl     = 6'h02,
		fn_sra     = 6'h03,
		fn_sllv    = 6'h04,
		fn_srlv    = 6'h06,
		fn_srav    = 6'h07,
		fn_jr      = 6'h08,
		fn_jalr    = 6'h09,
		fn_syscall = 6'h0c,
		fn_add     = 6'h20,
		fn_addu    = 6'h21,
		fn_sub     = 6'h22,
		fn_subu    = 6'h23,
		fn_and     = 6'h24,
		fn_or      = 6'h25,
		fn_xor     = 6'h26,
		fn_nor     = 6'h27,
		fn_slt     = 6'h2a,
		fn_sltu    = 6'h2b
	} funct_t;

	typedef enum logic [2:0] {
		br_none,
		br_always,
		br_eq,
		br_ne,
		br_gtz,
		br_lez,
		br_ltz,
		br_gez
	} br_cond_t;

	// where the branch target comes from
	typedef enum logic [1:0] {
		tgt_rel,
		tgt_jidx,
		tgt_reg
	} br_addr_sel_t;

endpackage

// File: common/pipe_pkg.sv
`include "decode_consts.svh"

package pipe_pkg;

	typedef logic [`WORD_W-1:0]     word_t;
	typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

	typedef enum logic [3:0] {
		alu_nop, alu_add, alu_addu, alu_sub, alu_subu,
		alu_and, alu_or, alu_xor, alu_nor, alu_slt,
		alu_sltu, alu_sll, alu_srl, alu_sra
	} alu_op_t;

	typedef enum logic [3:0] {
		mem_nop, mem_lb, mem_lbu, mem_lh, mem_lhu,
		mem_lw, mem_sb, mem_sh, mem_sw
	} mem_op_t;

	typedef enum logic [1:0] {
		exc_none,
		exc_undef,
		exc_trap
	} exc_code_t;

	// everything ex needs from one decoded instruction, 112 bits
	typedef struct packed {
		alu_op_t   alu_op;
		mem_op_t   mem_op;
		reg_addr_t dst_addr;
		logic      gpr_we;
		exc_code_t exc_code;
		word_t     alu_in_0;
		word_t     alu_in_1;
		word_t     mem_wr_data;
	} dec_ctrl_t;

endpackage

// File: common/stage_fwd_if.sv
`timescale 1ns/1ps

interface stage_fwd_if;
	import pipe_pkg::*;

	logic      en;
	logic      gpr_we;
	logic      is_load;
	reg_addr_t dst_addr;
	// value this stage's instruction will write back
	word_t     fwd_data;

	modport consumer (
		input en,
		input gpr_we,
		input is_load,
		input dst_addr,
		input fwd_data
	);

endinterface

// File: decode/decode_ctrl.sv
`timescale 1ns/1ps
`include "decode_consts.svh"

module decode_ctrl (
	input  pipe_pkg::word_t       insn,
	input  pipe_pkg::word_t       pc,
	input  pipe_pkg::word_t       rs_data,
	input  pipe_pkg::word_t       rt_data,
	output pipe_pkg::reg_addr_t   rs_addr,
	output pipe_pkg::reg_addr_t   rt_addr,
	output isa_pkg::br_cond_t     br_cond,
	output isa_pkg::br_addr_sel_t br_addr_sel,
	output logic                  br_flag,
	output pipe_pkg::dec_ctrl_t   ctrl
);
	import isa_pkg::*;
	import pipe_pkg::*;

	opcode_t   op;
	funct_t    fn;
	reg_addr_t rd_addr;
	word_t     shamt_u;
	word_t     imm_s;
	word_t     imm_u;
	word_t     imm_hi;
	word_t     ret_addr;

	// register-type alu ops, shifts map to the same op either way
	function automatic alu_op_t funct_alu(input funct_t f);
		case (f)
			fn_add:          return alu_add;
			fn_addu:         return alu_addu;
			fn_sub:          return alu_sub;
			fn_subu:         return alu_subu;
			fn_and:          return alu_and;
			fn_or:           return alu_or;
			fn_xor:          return alu_xor;
			fn_nor:          return alu_nor;
			fn_slt:          return alu_slt;
			fn_sltu:         return alu_sltu;
			fn_sll, fn_sllv: return alu_sll;
			fn_srl, fn_srlv: return alu_srl;
			fn_sra, fn_srav: return alu_sra;
			default:         return alu_nop;
		endcase
	endfunction

	function automatic mem_op_t opcode_mem(input opcode_t o);
		case (o)
			op_lb:   return mem_lb;
			op_lbu:  return mem_lbu;
			op_lh:   return mem_lh;
			op_lhu:  return mem_lhu;
			op_lw:   return mem_lw;
			op_sb:   return mem_sb;
			op_sh:   return mem_sh;
			op_sw:   return mem_sw;
			default: return mem_nop;
		endcase
	endfunction

	assign op       = opcode_t'(insn[`OP_MSB:`OP_LSB]);
	assign fn       = funct_t'(insn[`FUNCT_MSB:0]);
	assign rs_addr  = insn[`RS_LSB +: `REG_ADDR_W];
	assign rt_addr  = insn[`RT_LSB +: `REG_ADDR_W];
	assign rd_addr  = insn[`RD_LSB +: `REG_ADDR_W];
	assign shamt_u  = {{(`WORD_W-`SHAMT_W){1'b0}}, insn[`SHAMT_LSB +: `SHAMT_W]};
	assign imm_s    = {{(`WORD_W-`IMM_W){insn[`IMM_W-1]}}, insn[`IMM_W-1:0]};
	assign imm_u    = {{(`WORD_W-`IMM_W){1'b0}}, insn[`IMM_W-1:0]};
	assign imm_hi   = {insn[`IMM_W-1:0], {(`WORD_W-`IMM_W){1'b0}}};
	assign ret_addr = pc + `RET_OFFSET;
	assign br_flag  = (br_cond != br_none);

	always_comb begin
		ctrl.alu_op      = alu_nop;
		ctrl.mem_op      = mem_nop;
		ctrl.dst_addr    = rt_addr;
		ctrl.gpr_we      = 1'b0;
		ctrl.exc_code    = exc_none;
		ctrl.alu_in_0    = rs_data;
		ctrl.alu_in_1    = rt_data;
		ctrl.mem_wr_data = rt_data;
		br_cond          = br_none;
		br_addr_sel      = tgt_rel;
		case (op)
			op_special: begin
				case (fn)
					fn_add, fn_addu, fn_sub, fn_subu, fn_and,
					fn_or, fn_xor, fn_nor, fn_slt, fn_sltu: begin
						ctrl.alu_op   = funct_alu(fn);
						ctrl.dst_addr = rd_addr;
						ctrl.gpr_we   = 1'b1;
					end
					fn_sll, fn_srl, fn_sra: begin
						ctrl.alu_op   = funct_alu(fn);
						ctrl.alu_in_0 = rt_data;
						ctrl.alu_in_1 = shamt_u;
						ctrl.dst_addr = rd_addr;
						ctrl.gpr_we   = 1'b1;
					end
					// shift amount from rs
					fn_sllv, fn_srlv, fn_srav: begin
						ctrl.alu_op   = funct_alu(fn);
						ctrl.alu_in_0 = rt_data;
						ctrl.alu_in_1 = rs_data;
						ctrl.dst_addr = rd_addr;
						ctrl.gpr_we   = 1'b1;
					end
					fn_jr, fn_jalr: begin
						br_cond     = br_always;
						br_addr_sel = tgt_reg;
						if (fn == fn_jalr) begin
							ctrl.alu_op   = alu_addu;
							ctrl.alu_in_0 = ret_addr;
							ctrl.alu_in_1 = '0;
							ctrl.dst_addr = rd_addr;
							ctrl.gpr_we   = 1'b1;
						end
					end
					fn_syscall: ctrl.exc_code = exc_trap;
					default:    ctrl.exc_code = exc_undef;
				endcase
			end
			op_addi, op_addiu: begin
				ctrl.alu_op   = (op == op_addi) ? alu_add : alu_addu;
				ctrl.alu_in_1 = imm_s;
				ctrl.gpr_we   = 1'b1;
			end
			op_andi, op_ori, op_xori: begin
				ctrl.alu_op   = (op == op_andi) ? alu_and :
				                (op == op_ori)  ? alu_or  : alu_xor;
				ctrl.alu_in_1 = imm_u;
				ctrl.gpr_we   = 1'b1;
			end
			op_lui: begin
				ctrl.alu_op   = alu_addu;
				ctrl.alu_in_0 = '0;
				ctrl.alu_in_1 = imm_hi;
				ctrl.gpr_we   = 1'b1;
			end
			// effective address is rs plus the offset
			op_lb, op_lbu, op_lh, op_lhu, op_lw: begin
				ctrl.alu_op   = alu_addu;
				ctrl.alu_in_1 = imm_s;
				ctrl.mem_op   = opcode_mem(op);
				ctrl.gpr_we   = 1'b1;
			end
			op_sb, op_sh, op_sw: begin
				ctrl.alu_op   = alu_addu;
				ctrl.alu_in_1 = imm_s;
				ctrl.mem_op   = opcode_mem(op);
			end
			op_beq:  br_cond = br_eq;
			op_bne:  br_cond = br_ne;
			op_blez: br_cond = br_lez;
			op_bgtz: br_cond = br_gtz;
			// rt selects bltz or bgez
			op_regimm: begin
				case (rt_addr)
					5'd0:    br_cond = br_ltz;
					5'd1:    br_cond = br_gez;
					default: ctrl.exc_code = exc_undef;
				endcase
			end
			op_j, op_jal: begin
				br_cond     = br_always;
				br_addr_sel = tgt_jidx;
				if (op == op_jal) begin
					ctrl.alu_op   = alu_addu;
					ctrl.alu_in_0 = ret_addr;
					ctrl.alu_in_1 = '0;
					ctrl.dst_addr = `LINK_REG;
					ctrl.gpr_we   = 1'b1;
				end
			end
			default: ctrl.exc_code = exc_undef;
		endcase
	end

endmodule

// File: decode/operand_fwd.sv
`timescale 1ns/1ps

module operand_fwd (
	input  pipe_pkg::reg_addr_t rs_addr,
	input  pipe_pkg::reg_addr_t rt_addr,
	input  pipe_pkg::word_t     gpr_rd_data_0,
	input  pipe_pkg::word_t     gpr_rd_data_1,
	stage_fwd_if.consumer       id_st,
	stage_fwd_if.consumer       ex_st,
	stage_fwd_if.consumer       mem_st,
	output pipe_pkg::word_t     rs_data,
	output pipe_pkg::word_t     rt_data
);
	import pipe_pkg::*;

	// hit bit per stage, id first
	logic [2:0] rs_hit;
	logic [2:0] rt_hit;

	// youngest writer wins
	function automatic word_t fwd_mux(input logic [2:0] hit, input word_t id_data,
			input word_t ex_data, input word_t mem_data, input word_t gpr_data);
		if (hit[0])
			return id_data;
		else if (hit[1])
			return ex_data;
		else if (hit[2])
			return mem_data;
		return gpr_data;
	endfunction

	assign rs_hit[0] = id_st.en && id_st.gpr_we && (id_st.dst_addr == rs_addr);
	assign rs_hit[1] = ex_st.en && ex_st.gpr_we && (ex_st.dst_addr == rs_addr);
	assign rs_hit[2] = mem_st.en && mem_st.gpr_we && (mem_st.dst_addr == rs_addr);
	assign rt_hit[0] = id_st.en && id_st.gpr_we && (id_st.dst_addr == rt_addr);
	assign rt_hit[1] = ex_st.en && ex_st.gpr_we && (ex_st.dst_addr == rt_addr);
	assign rt_hit[2] = mem_st.en && mem_st.gpr_we && (mem_st.dst_addr == rt_addr);

	assign rs_data = fwd_mux(rs_hit, id_st.fwd_data, ex_st.fwd_data, mem_st.fwd_data,
	                         gpr_rd_data_0);
	assign rt_data = fwd_mux(rt_hit, id_st.fwd_data, ex_st.fwd_data, mem_st.fwd_data,
	                         gpr_rd_data_1);

endmodule

// File: decode/branch_unit.sv
`timescale 1ns/1ps
`include "decode_consts.svh"

module branch_unit (
	input  isa_pkg::br_cond_t     br_cond,
	input  isa_pkg::br_addr_sel_t br_addr_sel,
	input  pipe_pkg::word_t       pc,
	input  pipe_pkg::word_t       insn,
	input  pipe_pkg::word_t       rs_data,
	input  pipe_pkg::word_t       rt_data,
	output logic                  br_taken,
	output pipe_pkg::word_t       br_addr
);
	import isa_pkg::*;
	import pipe_pkg::*;

	word_t                     imm_s;
	word_t                     rel_target;
	word_t                     jmp_target;
	logic signed [`WORD_W-1:0] rs_s;

	assign imm_s      = {{(`WORD_W-`IMM_W){insn[`IMM_W-1]}}, insn[`IMM_W-1:0]};
	assign rel_target = pc + (imm_s << 2);
	// upper bits stay zero, the pc region is not merged in
	assign jmp_target = {{(`WORD_W-`JIDX_W-2){1'b0}}, insn[`JIDX_W-1:0], 2'b00};
	assign rs_s       = $signed(rs_data);

	always_comb begin
		case (br_cond)
			br_always: br_taken = 1'b1;
			br_eq:     br_taken = (rs_data == rt_data);
			br_ne:     br_taken = (rs_data != rt_data);
			br_gtz:    br_taken = (rs_s > 0);
			br_lez:    br_taken = (rs_s <= 0);
			br_ltz:    br_taken = (rs_s < 0);
			br_gez:    br_taken = (rs_s >= 0);
			default:   br_taken = 1'b0;
		endcase
	end

	always_comb begin
		case (br_addr_sel)
			tgt_jidx: br_addr = jmp_target;
			tgt_reg:  br_addr = rs_data;
			default:  br_addr = rel_target;
		endcase
	end

endmodule

// File: decode/load_hazard.sv
`timescale 1ns/1ps

module load_hazard (
	input  logic                valid,
	input  pipe_pkg::reg_addr_t rs_addr,
	input  pipe_pkg::reg_addr_t rt_addr,
	stage_fwd_if.consumer       id_st,
	stage_fwd_if.consumer       ex_st,
	output logic                ld_hazard
);
	import pipe_pkg::*;

	// load data is not ready before mem, so id and ex loads must stall
	function automatic logic load_blocks(input logic en, input logic is_load,
			input reg_addr_t dst, input reg_addr_t rs, input reg_addr_t rt);
		return en && is_load && ((dst == rs) || (dst == rt));
	endfunction

	assign ld_hazard = valid &&
		(load_blocks(id_st.en, id_st.is_load, id_st.dst_addr, rs_addr, rt_addr) ||
		 load_blocks(ex_st.en, ex_st.is_load, ex_st.dst_addr, rs_addr, rt_addr));

endmodule

// File: decode/id_ex_reg.sv
`timescale 1ns/1ps

module id_ex_reg (
	input  logic                clk,
	input  logic                arst_n,
	input  logic                valid,
	input  logic                ld_hazard,
	input  pipe_pkg::dec_ctrl_t ctrl,
	input  logic                nxt_br_flag,
	input  logic                nxt_br_taken,
	input  pipe_pkg::word_t     nxt_br_addr,
	output logic                dec_valid,
	output pipe_pkg::alu_op_t   dec_alu_op,
	output pipe_pkg::word_t     dec_alu_in_0,
	output pipe_pkg::word_t     dec_alu_in_1,
	output pipe_pkg::mem_op_t   dec_mem_op,
	output pipe_pkg::word_t     dec_mem_wr_data,
	output pipe_pkg::reg_addr_t dec_dst_addr,
	output logic                dec_gpr_we,
	output pipe_pkg::exc_code_t dec_exc_code,
	output logic                br_taken,
	output logic                br_flag,
	output pipe_pkg::word_t     br_addr
);
	import pipe_pkg::*;

	logic load;

	// a stalled or missing instruction becomes a bubble
	assign load = valid && !ld_hazard;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			dec_valid    <= 1'b0;
			dec_alu_op   <= alu_nop;
			dec_mem_op   <= mem_nop;
			dec_gpr_we   <= 1'b0;
			dec_exc_code <= exc_none;
			br_taken     <= 1'b0;
			br_flag      <= 1'b0;
		end else begin
			dec_valid    <= load;
			dec_alu_op   <= load ? ctrl.alu_op : alu_nop;
			dec_mem_op   <= load ? ctrl.mem_op : mem_nop;
			dec_gpr_we   <= load && ctrl.gpr_we;
			dec_exc_code <= load ? ctrl.exc_code : exc_none;
			br_taken     <= load && nxt_br_taken;
			br_flag      <= load && nxt_br_flag;
		end
	end

	// payload, only meaningful alongside dec_valid
	always_ff @(posedge clk) begin
		dec_alu_in_0    <= ctrl.alu_in_0;
		dec_alu_in_1    <= ctrl.alu_in_1;
		dec_mem_wr_data <= ctrl.mem_wr_data;
		dec_dst_addr    <= ctrl.dst_addr;
		br_addr         <= nxt_br_addr;
	end

endmodule

// File: hdl/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic                  if_en,
	input  pipe_pkg::word_t       if_pc,
	input  pipe_pkg::word_t       if_insn,
	input  pipe_pkg::word_t       gpr_rd_data_0,
	input  pipe_pkg::word_t       gpr_rd_data_1,
	output pipe_pkg::reg_addr_t   gpr_rd_addr_0,
	output pipe_pkg::reg_addr_t   gpr_rd_addr_1,
	input  logic                  id_en,
	input  logic                  id_gpr_we,
	input  logic                  id_is_load,
	input  pipe_pkg::reg_addr_t   id_dst_addr,
	input  logic                  ex_en,
	input  logic                  ex_gpr_we,
	input  logic                  ex_is_load,
	input  pipe_pkg::reg_addr_t   ex_dst_addr,
	input  logic                  mem_en,
	input  logic                  mem_gpr_we,
	input  logic                  mem_is_load,
	input  pipe_pkg::reg_addr_t   mem_dst_addr,
	input  pipe_pkg::word_t       ex_fwd_data,
	input  pipe_pkg::word_t       mem_fwd_data,
	input  pipe_pkg::word_t       wb_fwd_data,
	output logic                  ld_hazard,
	output logic                  dec_valid,
	output pipe_pkg::alu_op_t     dec_alu_op,
	output pipe_pkg::word_t       dec_alu_in_0,
	output pipe_pkg::word_t       dec_alu_in_1,
	output pipe_pkg::mem_op_t     dec_mem_op,
	output pipe_pkg::word_t       dec_mem_wr_data,
	output pipe_pkg::reg_addr_t   dec_dst_addr,
	output logic                  dec_gpr_we,
	output pipe_pkg::exc_code_t   dec_exc_code,
	output logic                  br_taken,
	output logic                  br_flag,
	output pipe_pkg::word_t       br_addr
);

	stage_fwd_if id_st ();
	stage_fwd_if ex_st ();
	stage_fwd_if mem_st ();

	pipe_pkg::reg_addr_t   rs_addr;
	pipe_pkg::reg_addr_t   rt_addr;
	pipe_pkg::word_t       rs_data;
	pipe_pkg::word_t       rt_data;
	isa_pkg::br_cond_t     br_cond;
	isa_pkg::br_addr_sel_t br_addr_sel;
	pipe_pkg::dec_ctrl_t   ctrl;
	logic                  nxt_br_flag;
	logic                  nxt_br_taken;
	pipe_pkg::word_t       nxt_br_addr;

	// each stage forwards the result one stage further down the pipe
	assign id_st.en        = id_en;
	assign id_st.gpr_we    = id_gpr_we;
	assign id_st.is_load   = id_is_load;
	assign id_st.dst_addr  = id_dst_addr;
	assign id_st.fwd_data  = ex_fwd_data;

	assign ex_st.en        = ex_en;
	assign ex_st.gpr_we    = ex_gpr_we;
	assign ex_st.is_load   = ex_is_load;
	assign ex_st.dst_addr  = ex_dst_addr;
	assign ex_st.fwd_data  = mem_fwd_data;

	assign mem_st.en       = mem_en;
	assign mem_st.gpr_we   = mem_gpr_we;
	assign mem_st.is_load  = mem_is_load;
	assign mem_st.dst_addr = mem_dst_addr;
	assign mem_st.fwd_data = wb_fwd_data;

	assign gpr_rd_addr_0 = rs_addr;
	assign gpr_rd_addr_1 = rt_addr;

	decode_ctrl i_decode_ctrl (
		.insn        (if_insn),
		.pc          (if_pc),
		.rs_data     (rs_data),
		.rt_data     (rt_data),
		.rs_addr     (rs_addr),
		.rt_addr     (rt_addr),
		.br_cond     (br_cond),
		.br_addr_sel (br_addr_sel),
		.br_flag     (nxt_br_flag),
		.ctrl        (ctrl)
	);

	operand_fwd i_operand_fwd (
		.rs_addr       (rs_addr),
		.rt_addr       (rt_addr),
		.gpr_rd_data_0 (gpr_rd_data_0),
		.gpr_rd_data_1 (gpr_rd_data_1),
		.id_st         (id_st),
		.ex_st         (ex_st),
		.mem_st        (mem_st),
		.rs_data       (rs_data),
		.rt_data       (rt_data)
	);

	branch_unit i_branch_unit (
		.br_cond     (br_cond),
		.br_addr_sel (br_addr_sel),
		.pc          (if_pc),
		.insn        (if_insn),
		.rs_data     (rs_data),
		.rt_data     (rt_data),
		.br_taken    (nxt_br_taken),
		.br_addr     (nxt_br_addr)
	);

	load_hazard i_load_hazard (
		.valid     (if_en),
		.rs_addr   (rs_addr),
		.rt_addr   (rt_addr),
		.id_st     (id_st),
		.ex_st     (ex_st),
		.ld_hazard (ld_hazard)
	);

	id_ex_reg i_id_ex_reg (
		.clk             (clk),
		.arst_n          (arst_n),
		.valid           (if_en),
		.ld_hazard       (ld_hazard),
		.ctrl            (ctrl),
		.nxt_br_flag     (nxt_br_flag),
		.nxt_br_taken    (nxt_br_taken),
		.nxt_br_addr     (nxt_br_addr),
		.dec_valid       (dec_valid),
		.dec_alu_op      (dec_alu_op),
		.dec_alu_in_0    (dec_alu_in_0),
		.dec_alu_in_1    (dec_alu_in_1),
		.dec_mem_op      (dec_mem_op),
		.dec_mem_wr_data (dec_mem_wr_data),
		.dec_dst_addr    (dec_dst_addr),
		.dec_gpr_we      (dec_gpr_we),
		.dec_exc_code    (dec_exc_code),
		.br_taken        (br_taken),
		.br_flag         (br_flag),
		.br_addr         (br_addr)
	);

endmodule

// File: verif/tb_decode_tasks.svh
`ifndef TB_DECODE_TASKS_SVH
`define TB_DECODE_TASKS_SVH

// xorshift32 on the shared state
function automatic word_t next_random();
	rng_state ^= rng_state << 13;
	rng_state ^= rng_state >> 17;
	rng_state ^= rng_state << 5;
	return rng_state;
endfunction

function automatic word_t rtype_insn(input reg_addr_t rs, input reg_addr_t rt,
		input reg_addr_t rd, input logic [4:0] shamt, input logic [5:0] funct);
	return {6'h00, rs, rt, rd, shamt, funct};
endfunction

function automatic word_t imm_insn(input logic [5:0] op, input reg_addr_t rs,
		input reg_addr_t rt, input logic [15:0] imm);
	return {op, rs, rt, imm};
endfunction

function automatic word_t jump_insn(input logic [5:0] op, input logic [25:0] idx);
	return {op, idx};
endfunction

function automatic word_t sign_extend(input logic [15:0] imm);
	return {{16{imm[15]}}, imm};
endfunction

task automatic check_eq(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
	checks++;
	if (actual !== expected) begin
		errors++;
		$display("** Error at %0t ns: %s expected 0x%08h, got 0x%08h",
		         $time, name, expected, actual);
	end
endtask

task automatic report_test(input string name, input int err_start);
	tests_run++;
	if (errors == err_start) begin
		$display("%-12s ok", name);
	end else begin
		tests_failed++;
		$display("%-12s failed with %0d errors", name, errors - err_start);
	end
endtask

task automatic clear_stages();
	id_en = 1'b0;
	id_gpr_we = 1'b0;
	id_is_load = 1'b0;
	id_dst_addr = '0;
	ex_en = 1'b0;
	ex_gpr_we = 1'b0;
	ex_is_load = 1'b0;
	ex_dst_addr = '0;
	mem_en = 1'b0;
	mem_gpr_we = 1'b0;
	mem_is_load = 1'b0;
	mem_dst_addr = '0;
	ex_fwd_data = '0;
	mem_fwd_data = '0;
	wb_fwd_data = '0;
endtask

// next drive point with the stages back at idle
task automatic begin_cycle();
	@(posedge clk);
	#2;
	clear_stages();
endtask

// present one instruction and wait until it shows on the outputs
task automatic run_insn(input word_t pc, input word_t insn, input word_t rs_val,
		input word_t rt_val);
	int cycles;
	if_en = 1'b1;
	if_pc = pc;
	if_insn = insn;
	gpr_rd_data_0 = rs_val;
	gpr_rd_data_1 = rt_val;
	cycles = 0;
	do begin
		@(posedge clk);
		#1;
		cycles++;
	end while (!dec_valid && cycles < wait_limit);
	if (!dec_valid) begin
		errors++;
		$display("timeout: dec_valid stayed low for instruction 0x%08h", insn);
	end
endtask

task automatic check_decode(input string name, input alu_op_t op, input word_t in0,
		input word_t in1, input reg_addr_t dst, input logic we, input mem_op_t mop,
		input word_t wr_data);
	check_eq({name, " dec_alu_op"}, op, dec_alu_op);
	check_eq({name, " dec_alu_in_0"}, in0, dec_alu_in_0);
	check_eq({name, " dec_alu_in_1"}, in1, dec_alu_in_1);
	check_eq({name, " dec_dst_addr"}, dst, dec_dst_addr);
	check_eq({name, " dec_gpr_we"}, we, dec_gpr_we);
	check_eq({name, " dec_mem_op"}, mop, dec_mem_op);
	check_eq({name, " dec_mem_wr_data"}, wr_data, dec_mem_wr_data);
	check_eq({name, " br_flag"}, 1'b0, br_flag);
endtask

task automatic reset_state();
	int err_start;
	err_start = errors;
	@(posedge clk);
	#1;
	check_eq("dec_valid", 1'b0, dec_valid);
	check_eq("dec_gpr_we", 1'b0, dec_gpr_we);
	check_eq("br_taken", 1'b0, br_taken);
	check_eq("br_flag", 1'b0, br_flag);
	check_eq("dec_alu_op", alu_nop, dec_alu_op);
	check_eq("dec_mem_op", mem_nop, dec_mem_op);
	check_eq("dec_exc_code", exc_none, dec_exc_code);
	report_test("reset", err_start);
endtask

task automatic alu_decode();
	int          err_start;
	word_t       a;
	word_t       b;
	word_t       pc;
	logic [15:0] imm;
	logic [4:0]  sh;
	err_start = errors;
	a = next_random();
	b = next_random();
	pc = next_random() & ~32'h3;
	imm = 16'(next_random());
	sh = 5'(next_random());

	begin_cycle();
	run_insn(pc, rtype_insn(5'd2, 5'd3, 5'd4, 5'd0, 6'h20), a, b);
	check_decode("add", alu_add, a, b, 5'd4, 1'b1, mem_nop, b);
	begin_cycle();
	run_insn(pc, rtype_insn(5'd2, 5'd3, 5'd4, 5'd0, 6'h22), a, b);
	check_decode("sub", alu_sub, a, b, 5'd4, 1'b1, mem_nop, b);
	begin_cycle();
	run_insn(pc, rtype_insn(5'd2, 5'd3, 5'd4, 5'd0, 6'h2a), a, b);
	check_decode("slt", alu_slt, a, b, 5'd4, 1'b1, mem_nop, b);
	begin_cycle();
	run_insn(pc, rtype_insn(5'd2, 5'd3, 5'd4, 5'd0, 6'h27), a, b);
	check_decode("nor", alu_nor, a, b, 5'd4, 1'b1, mem_nop, b);

	// shifts take rt first
	begin_cycle();
	run_insn(pc, rtype_insn(5'd0, 5'd3, 5'd4, sh, 6'h00), a, b);
	check_decode("sll", alu_sll, b, {27'd0, sh}, 5'd4, 1'b1, mem_nop, b);
	begin_cycle();
	run_insn(pc, rtype_insn(5'd2, 5'd3, 5'd4, 5'd0, 6'h07), a, b);
	check_decode("srav", alu_sra, b, a, 5'd4, 1'b1, mem_nop, b);

	begin_cycle();
	run_insn(pc, imm_insn(6'h08, 5'd2, 5'd6, imm), a, b);
	check_decode("addi", alu_add, a, sign_extend(imm), 5'd6, 1'b1, mem_nop, b);
	begin_cycle();
	run_insn(pc, imm_insn(6'h0d, 5'd2, 5'd6, imm), a, b);
	check_decode("ori", alu_or, a, {16'h0, imm}, 5'd6, 1'b1, mem_nop, b);
	begin_cycle();
	run_insn(pc, imm_insn(6'h0f, 5'd0, 5'd6, imm), a, b);
	check_decode("lui", alu_addu, 32'd0, {imm, 16'h0}, 5'd6, 1'b1, mem_nop, b);

	begin_cycle();
	run_insn(pc, imm_insn(6'h23, 5'd2, 5'd6, imm), a, b);
	check_decode("lw", alu_addu, a, sign_extend(imm), 5'd6, 1'b1, mem_lw, b);
	begin_cycle();
	run_insn(pc, imm_insn(6'h2b, 5'd2, 5'd6, imm), a, b);
	check_decode("sw", alu_addu, a, sign_extend(imm), 5'd6, 1'b0, mem_sw, b);
	report_test("alu decode", err_start);
endtask

// add r10, r7, r9 with the stages in match writing reg_sel
task automatic forward_step(input string name, input logic [2:0] match,
		input reg_addr_t reg_sel, input word_t expected, input logic on_rt);
	begin_cycle();
	id_en = match[0];
	id_gpr_we = match[0];
	id_dst_addr = reg_sel;
	ex_en = match[1];
	ex_gpr_we = match[1];
	ex_dst_addr = reg_sel;
	mem_en = match[2];
	mem_gpr_we = match[2];
	mem_dst_addr = reg_sel;
	ex_fwd_data = fwd_vals[0];
	mem_fwd_data = fwd_vals[1];
	wb_fwd_data = fwd_vals[2];
	run_insn(32'h0, rtype_insn(5'd7, 5'd9, 5'd10, 5'd0, 6'h20), gpr_vals[0], gpr_vals[1]);
	check_eq({name, " gpr_rd_addr_0"}, 5'd7, gpr_rd_addr_0);
	check_eq({name, " gpr_rd_addr_1"}, 5'd9, gpr_rd_addr_1);
	if (on_rt)
		check_eq({name, " dec_alu_in_1"}, expected, dec_alu_in_1);
	else
		check_eq({name, " dec_alu_in_0"}, expected, dec_alu_in_0);
endtask

task automatic forwarding_order();
	int err_start;
	err_start = errors;
	for (int i = 0; i < 3; i++)
		fwd_vals[i] = next_random();
	gpr_vals[0] = next_random();
	gpr_vals[1] = next_random();
	forward_step("rs id", 3'b111, 5'd7, fwd_vals[0], 1'b0);
	forward_step("rs ex", 3'b110, 5'd7, fwd_vals[1], 1'b0);
	forward_step("rs mem", 3'b100, 5'd7, fwd_vals[2], 1'b0);
	forward_step("rs gpr", 3'b000, 5'd7, gpr_vals[0], 1'b0);
	forward_step("rt id", 3'b111, 5'd9, fwd_vals[0], 1'b1);
	forward_step("rt ex", 3'b110, 5'd9, fwd_vals[1], 1'b1);
	forward_step("rt mem", 3'b100, 5'd9, fwd_vals[2], 1'b1);
	forward_step("rt gpr", 3'b000, 5'd9, gpr_vals[1], 1'b1);
	report_test("forwarding", err_start);
endtask

task automatic branch_case(input string name, input word_t pc, input word_t insn,
		input word_t a, input word_t b, input logic taken, input word_t target);
	begin_cycle();
	run_insn(pc, insn, a, b);
	check_eq({name, " br_flag"}, 1'b1, br_flag);
	check_eq({name, " br_taken"}, taken, br_taken);
	check_eq({name, " br_addr"}, target, br_addr);
endtask

task automatic branch_decode();
	int          err_start;
	word_t       pc;
	word_t       a;
	word_t       b;
	word_t       rel;
	word_t       jt;
	logic [15:0] imm;
	logic [25:0] idx;
	err_start = errors;
	pc = next_random() & ~32'h3;
	imm = 16'(next_random());
	a = next_random();
	b = a ^ (next_random() | 32'h1);
	idx = 26'(next_random());
	rel = pc + (sign_extend(imm) << 2);
	jt = {4'h0, idx, 2'b00};

	branch_case("beq taken", pc, imm_insn(6'h04, 5'd1, 5'd2, imm), a, a, 1'b1, rel);
	branch_case("beq not", pc, imm_insn(6'h04, 5'd1, 5'd2, imm), a, b, 1'b0, rel);
	branch_case("bne taken", pc, imm_insn(6'h05, 5'd1, 5'd2, imm), a, b, 1'b1, rel);
	branch_case("bne not", pc, imm_insn(6'h05, 5'd1, 5'd2, imm), a, a, 1'b0, rel);
	branch_case("bgtz", pc, imm_insn(6'h07, 5'd1, 5'd0, imm), a, b, $signed(a) > 0, rel);
	branch_case("blez", pc, imm_insn(6'h06, 5'd1, 5'd0, imm), a, b, $signed(a) <= 0, rel);
	branch_case("bltz", pc, imm_insn(6'h01, 5'd1, 5'd0, imm), b, a, $signed(b) < 0, rel);
	branch_case("bgez", pc, imm_insn(6'h01, 5'd1, 5'd1, imm), b, a, $signed(b) >= 0, rel);
	branch_case("j", pc, jump_insn(6'h02, idx), a, b, 1'b1, jt);
	branch_case("jal", pc, jump_insn(6'h03, idx), a, b, 1'b1, jt);
	check_eq("jal dec_dst_addr", 5'd31, dec_dst_addr);
	check_eq("jal dec_alu_in_0", pc + 32'd8, dec_alu_in_0);
	check_eq("jal dec_gpr_we", 1'b1, dec_gpr_we);
	branch_case("jr", pc, rtype_insn(5'd1, 5'd0, 5'd0, 5'd0, 6'h08), a, b, 1'b1, a);
	report_test("branches", err_start);
endtask

// add r14, r12, r13 against one writer in the stage picked by st
task automatic hazard_case(input string name, input logic [2:0] st, input logic is_load,
		input reg_addr_t dst, input logic exp_hz);
	begin_cycle();
	id_en = st[0];
	id_gpr_we = st[0];
	id_is_load = st[0] && is_load;
	id_dst_addr = dst;
	ex_en = st[1];
	ex_gpr_we = st[1];
	ex_is_load = st[1] && is_load;
	ex_dst_addr = dst;
	mem_en = st[2];
	mem_gpr_we = st[2];
	mem_is_load = st[2] && is_load;
	mem_dst_addr = dst;
	if_en = 1'b1;
	if_pc = '0;
	if_insn = rtype_insn(5'd12, 5'd13, 5'd14, 5'd0, 6'h20);
	gpr_rd_data_0 = next_random();
	gpr_rd_data_1 = next_random();
	#1;
	check_eq({name, " ld_hazard"}, exp_hz, ld_hazard);
	@(posedge clk);
	#1;
	check_eq({name, " dec_valid"}, !exp_hz, dec_valid);
endtask

task automatic hazard_stall();
	int err_start;
	err_start = errors;
	hazard_case("id load rs", 3'b001, 1'b1, 5'd12, 1'b1);
	hazard_case("ex load rt", 3'b010, 1'b1, 5'd13, 1'b1);
	hazard_case("mem load rs", 3'b100, 1'b1, 5'd12, 1'b0);
	hazard_case("id alu rs", 3'b001, 1'b0, 5'd12, 1'b0);
	report_test("load hazard", err_start);
endtask

task automatic exception_decode();
	int    err_start;
	word_t a;
	word_t b;
	err_start = errors;
	a = next_random();
	b = next_random();
	begin_cycle();
	run_insn(32'h100, rtype_insn(5'd0, 5'd0, 5'd0, 5'd0, 6'h0c), a, b);
	check_eq("syscall dec_exc_code", exc_trap, dec_exc_code);
	check_eq("syscall dec_gpr_we", 1'b0, dec_gpr_we);
	check_eq("syscall dec_mem_op", mem_nop, dec_mem_op);
	// 0x3f is no opcode of the set
	begin_cycle();
	run_insn(32'h104, jump_insn(6'h3f, 26'(next_random())), a, b);
	check_eq("undef dec_exc_code", exc_undef, dec_exc_code);
	check_eq("undef dec_gpr_we", 1'b0, dec_gpr_we);
	check_eq("undef dec_mem_op", mem_nop, dec_mem_op);
	report_test("exceptions", err_start);
endtask

`endif

// File: verif/tb_decode_stage.sv
`timescale 1ns/1ps

module tb_decode_stage;
	import pipe_pkg::*;

	// cycles any handshake wait may take
	localparam int wait_limit = 20;

	logic      clk;
	logic      arst_n;
	logic      if_en;
	word_t     if_pc;
	word_t     if_insn;
	word_t     gpr_rd_data_0;
	word_t     gpr_rd_data_1;
	reg_addr_t gpr_rd_addr_0;
	reg_addr_t gpr_rd_addr_1;
	logic      id_en;
	logic      id_gpr_we;
	logic      id_is_load;
	reg_addr_t id_dst_addr;
	logic      ex_en;
	logic      ex_gpr_we;
	logic      ex_is_load;
	reg_addr_t ex_dst_addr;
	logic      mem_en;
	logic      mem_gpr_we;
	logic      mem_is_load;
	reg_addr_t mem_dst_addr;
	word_t     ex_fwd_data;
	word_t     mem_fwd_data;
	word_t     wb_fwd_data;
	logic      ld_hazard;
	logic      dec_valid;
	alu_op_t   dec_alu_op;
	word_t     dec_alu_in_0;
	word_t     dec_alu_in_1;
	mem_op_t   dec_mem_op;
	word_t     dec_mem_wr_data;
	reg_addr_t dec_dst_addr;
	logic      dec_gpr_we;
	exc_code_t dec_exc_code;
	logic      br_taken;
	logic      br_flag;
	word_t     br_addr;

	int        errors;
	int        checks;
	int        tests_run;
	int        tests_failed;
	word_t     rng_state;
	// forwarded results of id, ex, mem and the two register file reads
	word_t     fwd_vals [3];
	word_t     gpr_vals [2];

	decode_stage i_dut (.*);

	`include "tb_decode_tasks.svh"

	always #10 clk = ~clk;

	initial begin
		clk = 1'b0;
		arst_n = 1'b0;
		rng_state = 32'd39;
		errors = 0;
		checks = 0;
		tests_run = 0;
		tests_failed = 0;
		if_en = 1'b0;
		if_pc = '0;
		if_insn = '0;
		gpr_rd_data_0 = '0;
		gpr_rd_data_1 = '0;
		clear_stages();
		repeat (10) @(posedge clk);
		#2;
		arst_n = 1'b1;

		reset_state();
		alu_decode();
		forwarding_order();
		branch_decode();
		hazard_stall();
		exception_decode();

		$display("tests %0d, failed %0d, checks %0d, errors %0d",
		         tests_run, tests_failed, checks, errors);
		if (errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

// File: sources.f
+incdir+common
+incdir+verif
common/isa_pkg.sv
common/pipe_pkg.sv
common/stage_fwd_if.sv
decode/decode_ctrl.sv
decode/operand_fwd.sv
decode/branch_unit.sv
decode/load_hazard.sv
decode/id_ex_reg.sv
hdl/decode_stage.sv
verif/tb_decode_stage.sv
